// ==== Bender.yml ====
package:
  name: aib_link

sources:
  # package first, then leaf modules up to the top level
  - design/aib_pkg.sv
  - design/aib_avmm_csr.sv
  - design/aib_tx_path.sv
  - design/aib_rx_path.sv
  - design/aib_channel.sv
  - design/emib_ch_m2s2.sv
  - design/aib_link_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/aib_link_tb.sv

// ==== aib_link.f ====
+incdir+verif
design/aib_pkg.sv
design/aib_avmm_csr.sv
design/aib_tx_path.sv
design/aib_rx_path.sv
design/aib_channel.sv
design/emib_ch_m2s2.sv
design/aib_link_top.sv
verif/aib_link_tb.sv

// ==== design/aib_avmm_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module aib_avmm_csr
   import aib_pkg::*;
(
   input  wire  logic       wr_clk,
   input  wire  logic       rst_n,
   input  wire  avmm_req_t  avmm_req,
   output       avmm_rsp_t  avmm_rsp,
   output       logic       tx_en,
   input  wire  logic       tx_fire,
   input  wire  logic       rx_fire,
   input  wire  logic       aligned,
   input  wire  logic [3:0] credits
);

   logic                       tx_en_q;       // control bit.
   logic [15:0]                tx_words_q;    // words sent, wraps.
   logic [15:0]                rx_words_q;    // words delivered, wraps.
   logic                       rvalid_q;      // read response strobe.
   logic [AVMM_DATA_WIDTH-1:0] rdata_q;       // read response data.
   logic [AVMM_DATA_WIDTH-1:0] rdata_d;       // read mux output.
   csr_addr_e                  addr;          // decoded address.

   assign addr = csr_addr_e'(avmm_req.address);

   // read mux, registered below.
   always_comb
   begin
      rdata_d = '0;
      case (addr)
         REG_CTRL:     rdata_d = {15'h0, tx_en_q};
         REG_STATUS:   rdata_d = {8'h0, credits, 3'b000, aligned};
         REG_TX_WORDS: rdata_d = tx_words_q;
         REG_RX_WORDS: rdata_d = rx_words_q;
         default:      rdata_d = '0;            // unmapped reads as zero.
      endcase
   end

   // control and counters.
   always_ff @(posedge wr_clk)
   begin
      if (!rst_n)
      begin
         tx_en_q    <= 1'b0;
         tx_words_q <= '0;
         rx_words_q <= '0;
         rvalid_q   <= 1'b0;
      end
      else
      begin
         if (avmm_req.write && addr == REG_CTRL)
         begin
            tx_en_q <= avmm_req.writedata[0];   // takes effect this edge.
         end
         tx_words_q <= tx_words_q + 16'(tx_fire); // one per accepted word.
         rx_words_q <= rx_words_q + 16'(rx_fire); // one per popped word.
         rvalid_q   <= avmm_req.read;           // fixed one-cycle latency.
      end
   end

   // read data, valid only with rvalid_q.
   always_ff @(posedge wr_clk)
   begin
      if (avmm_req.read)
      begin
         rdata_q <= rdata_d;
      end
   end

   assign tx_en                  = tx_en_q;
   assign avmm_rsp.readdata      = rdata_q;
   assign avmm_rsp.readdatavalid = rvalid_q;

endmodule : aib_avmm_csr

`default_nettype wire

// ==== design/aib_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module aib_channel
   import aib_pkg::*;
#(
   parameter int RX_DEPTH = 4                   // receive depth and credits.
)
(
   input  wire logic      wr_clk,
   input  wire logic      rst_n,
   input  wire avmm_req_t avmm_req,
   output      avmm_rsp_t avmm_rsp,
   input  wire logic      tx_valid,
   input  wire aib_word_t tx_data,
   output      logic      tx_ready,
   output      logic      rx_valid,
   output      aib_word_t rx_data,
   input  wire logic      rx_ready,
   output      aib_pad_t  pad_out,
   input  wire aib_pad_t  pad_in
);

   logic                  tx_en;                // from control register.
   logic                  tx_fire;              // word accepted.
   logic                  rx_fire;              // word delivered.
   logic                  aligned;
   logic [3:0]            credits;
   logic [BEAT_WIDTH-1:0] tx_beat;
   logic                  tx_beat_valid;
   logic                  tx_marker;
   logic                  credit_out;           // slot returned to far side.

   aib_avmm_csr u_csr (
      .wr_clk   (wr_clk),
      .rst_n    (rst_n),
      .avmm_req (avmm_req),
      .avmm_rsp (avmm_rsp),
      .tx_en    (tx_en),
      .tx_fire  (tx_fire),
      .rx_fire  (rx_fire),
      .aligned  (aligned),
      .credits  (credits)
   );

   aib_tx_path #(.RX_DEPTH(RX_DEPTH)) u_tx (
      .wr_clk     (wr_clk),
      .rst_n      (rst_n),
      .tx_en      (tx_en),
      .tx_valid   (tx_valid),
      .tx_data    (tx_data),
      .tx_ready   (tx_ready),
      .tx_fire    (tx_fire),
      .credit_in  (pad_in.credit),              // far receiver frees a slot.
      .credits    (credits),
      .beat       (tx_beat),
      .beat_valid (tx_beat_valid),
      .marker     (tx_marker)
   );

   aib_rx_path #(.RX_DEPTH(RX_DEPTH)) u_rx (
      .wr_clk     (wr_clk),
      .rst_n      (rst_n),
      .beat       (pad_in.data),
      .beat_valid (pad_in.beat_valid),
      .marker     (pad_in.marker),
      .rx_valid   (rx_valid),
      .rx_data    (rx_data),
      .rx_ready   (rx_ready),
      .rx_fire    (rx_fire),
      .credit_out (credit_out),
      .aligned    (aligned)
   );

   // outgoing bundle, credit rides against the data.
   assign pad_out = '{data: tx_beat, beat_valid: tx_beat_valid,
                      marker: tx_marker, credit: credit_out};

endmodule : aib_channel

`default_nettype wire

// ==== design/aib_link_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aib_link_top
   import aib_pkg::*;
#(
   parameter int RX_DEPTH      = 4,             // receive depth per channel.
   parameter int BRIDGE_STAGES = 2              // interposer latency.
)
(
   input  wire logic      wr_clk,
   input  wire logic      rst_n,
   input  wire avmm_req_t ms_avmm_req,
   output      avmm_rsp_t ms_avmm_rsp,
   input  wire avmm_req_t sl_avmm_req,
   output      avmm_rsp_t sl_avmm_rsp,
   input  wire logic      ms_tx_valid,
   input  wire aib_word_t ms_tx_data,
   output      logic      ms_tx_ready,
   output      logic      ms_rx_valid,
   output      aib_word_t ms_rx_data,
   input  wire logic      ms_rx_ready,
   input  wire logic      sl_tx_valid,
   input  wire aib_word_t sl_tx_data,
   output      logic      sl_tx_ready,
   output      logic      sl_rx_valid,
   output      aib_word_t sl_rx_data,
   input  wire logic      sl_rx_ready
);

   aib_pad_t m_pad_out, m_pad_in;               // master side of the bridge.
   aib_pad_t s_pad_out, s_pad_in;               // slave side of the bridge.

   aib_channel #(.RX_DEPTH(RX_DEPTH)) dut_master1 (
      .wr_clk   (wr_clk),       .rst_n    (rst_n),
      .avmm_req (ms_avmm_req),  .avmm_rsp (ms_avmm_rsp),
      .tx_valid (ms_tx_valid),  .tx_data  (ms_tx_data),  .tx_ready (ms_tx_ready),
      .rx_valid (ms_rx_valid),  .rx_data  (ms_rx_data),  .rx_ready (ms_rx_ready),
      .pad_out  (m_pad_out),    .pad_in   (m_pad_in)
   );

   aib_channel #(.RX_DEPTH(RX_DEPTH)) dut_slave1 (
      .wr_clk   (wr_clk),       .rst_n    (rst_n),
      .avmm_req (sl_avmm_req),  .avmm_rsp (sl_avmm_rsp),
      .tx_valid (sl_tx_valid),  .tx_data  (sl_tx_data),  .tx_ready (sl_tx_ready),
      .rx_valid (sl_rx_valid),  .rx_data  (sl_rx_data),  .rx_ready (sl_rx_ready),
      .pad_out  (s_pad_out),    .pad_in   (s_pad_in)
   );

   emib_ch_m2s2 #(.BRIDGE_STAGES(BRIDGE_STAGES)) dut_emib (
      .wr_clk    (wr_clk),
      .rst_n     (rst_n),
      .m_aib_out (m_pad_out),
      .m_aib_in  (m_pad_in),
      .s_aib_out (s_pad_out),
      .s_aib_in  (s_pad_in)
   );

endmodule : aib_link_top

`default_nettype wire

// ==== design/aib_pkg.sv ====
`default_nettype none

package aib_pkg;

   // pad and word geometry.
   localparam int BEAT_WIDTH = 40;              // one pad beat.
   localparam int WORD_WIDTH = 2 * BEAT_WIDTH;  // one user word, two beats.

   // register bus widths.
   localparam int AVMM_ADDR_WIDTH = 4;
   localparam int AVMM_DATA_WIDTH = 16;

   typedef logic [WORD_WIDTH-1:0] aib_word_t;   // user word.

   // bundle one channel drives toward the bridge.
   typedef struct packed
   {
      logic [BEAT_WIDTH-1:0] data;              // beat payload.
      logic                  beat_valid;        // beat present this cycle.
      logic                  marker;            // first beat of a word.
      logic                  credit;            // one buffer slot returned.
   } aib_pad_t;

   // register request, one cycle per access.
   typedef struct packed
   {
      logic [AVMM_ADDR_WIDTH-1:0] address;      // register index.
      logic                       write;        // write strobe.
      logic                       read;         // read strobe.
      logic [AVMM_DATA_WIDTH-1:0] writedata;    // write payload.
   } avmm_req_t;

   // register response, always one cycle after the read.
   typedef struct packed
   {
      logic [AVMM_DATA_WIDTH-1:0] readdata;     // read payload.
      logic                       readdatavalid;// read payload valid.
   } avmm_rsp_t;

   // register map.
   typedef enum logic [AVMM_ADDR_WIDTH-1:0]
   {
      REG_CTRL     = 4'h0,                      // bit 0 tx_en.
      REG_STATUS   = 4'h1,                      // bit 0 aligned, 7:4 credits.
      REG_TX_WORDS = 4'h2,                      // words sent.
      REG_RX_WORDS = 4'h3                       // words delivered.
   } csr_addr_e;

   // receive aligner states.
   typedef enum logic [1:0]
   {
      HUNT   = 2'd0,                            // waiting for a marker.
      FIRST  = 2'd1,                            // next beat opens a word.
      SECOND = 2'd2                             // next beat closes a word.
   } align_state_e;

endpackage : aib_pkg

`default_nettype wire

// ==== design/aib_rx_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module aib_rx_path
   import aib_pkg::*;
#(
   parameter int RX_DEPTH = 4                   // receive buffer depth.
)
(
   input  wire logic                  wr_clk,
   input  wire logic                  rst_n,
   input  wire logic [BEAT_WIDTH-1:0] beat,
   input  wire logic                  beat_valid,
   input  wire logic                  marker,
   output      logic                  rx_valid,
   output      aib_word_t             rx_data,
   input  wire logic                  rx_ready,
   output      logic                  rx_fire,
   output      logic                  credit_out,
   output      logic                  aligned
);

   localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
   localparam int CNT_W = $clog2(RX_DEPTH + 1);

   align_state_e          state_q, state_d;     // aligner.
   logic                  push;                 // word complete this edge.
   logic                  aligned_q;
   logic [BEAT_WIDTH-1:0] lo_q;                 // first beat held.
   aib_word_t             mem [RX_DEPTH];       // circular buffer.
   logic [PTR_W-1:0]      wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0]      count_q;              // words held.
   logic                  rx_valid_q;
   logic                  credit_q;

   // marker alignment and beat pairing.
   always_comb
   begin
      state_d = state_q;
      push    = 1'b0;
      if (beat_valid)
      begin
         case (state_q)
            HUNT:    if (marker) state_d = SECOND;      // lock on first marker.
            FIRST:   state_d = marker ? SECOND : HUNT;  // lost alignment.
            SECOND:
            begin
               if (!marker)
               begin
                  push    = 1'b1;               // word rebuilt.
                  state_d = FIRST;
               end
            end
            default: state_d = HUNT;
         endcase
      end
   end

   assign rx_fire = rx_valid_q && rx_ready;     // user pop.

   always_ff @(posedge wr_clk)
   begin
      if (!rst_n)
      begin
         state_q    <= HUNT;
         aligned_q  <= 1'b0;
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         rx_valid_q <= 1'b0;
         credit_q   <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (push)
            aligned_q <= 1'b1;
         else if (beat_valid && state_q == FIRST && !marker)
            aligned_q <= 1'b0;                  // unmarked opener.
         if (push)
            wr_ptr_q <= (wr_ptr_q == PTR_W'(RX_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (rx_fire)
            rd_ptr_q <= (rd_ptr_q == PTR_W'(RX_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         count_q    <= count_q + CNT_W'(push) - CNT_W'(rx_fire);
         // a new word shows one edge after its write.
         rx_valid_q <= rx_fire ? (count_q > CNT_W'(1)) : (count_q != '0);
         credit_q   <= rx_fire;                 // one slot back per pop.
      end
   end

   // payload storage.
   always_ff @(posedge wr_clk)
   begin
      if (beat_valid && marker)
         lo_q <= beat;                          // low half.
      if (push)
         mem[wr_ptr_q] <= {beat, lo_q};
   end

   assign rx_data    = mem[rd_ptr_q];           // stable until popped.
   assign rx_valid   = rx_valid_q;
   assign credit_out = credit_q;
   assign aligned    = aligned_q;

endmodule : aib_rx_path

`default_nettype wire

// ==== design/aib_tx_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module aib_tx_path
   import aib_pkg::*;
#(
   parameter int RX_DEPTH = 4                   // far buffer depth, initial credits.
)
(
   input  wire logic                  wr_clk,
   input  wire logic                  rst_n,
   input  wire logic                  tx_en,
   input  wire logic                  tx_valid,
   input  wire aib_word_t             tx_data,
   output      logic                  tx_ready,
   output      logic                  tx_fire,
   input  wire logic                  credit_in,
   output      logic [3:0]            credits,
   output      logic [BEAT_WIDTH-1:0] beat,
   output      logic                  beat_valid,
   output      logic                  marker
);

   logic [3:0]            credits_q;            // slots free at the far end.
   logic                  pending_q;            // high half still to send.
   logic                  beat_valid_q;         // pad valid.
   logic                  marker_q;             // pad marker.
   logic [BEAT_WIDTH-1:0] beat_q;               // pad payload.
   logic [BEAT_WIDTH-1:0] hi_q;                 // held upper half.

   // accept only with credit and a free beat slot.
   assign tx_ready = tx_en && (credits_q != 4'd0) && !pending_q;
   assign tx_fire  = tx_valid && tx_ready;

   // credit counter and beat sequencing.
   always_ff @(posedge wr_clk)
   begin
      if (!rst_n)
      begin
         credits_q    <= 4'(RX_DEPTH);
         pending_q    <= 1'b0;
         beat_valid_q <= 1'b0;
         marker_q     <= 1'b0;
      end
      else
      begin
         // return and spend may land together.
         credits_q <= credits_q + 4'(credit_in) - 4'(tx_fire);
         if (tx_fire)
         begin
            pending_q    <= 1'b1;               // second beat next cycle.
            beat_valid_q <= 1'b1;
            marker_q     <= 1'b1;               // flags the low half.
         end
         else if (pending_q)
         begin
            pending_q    <= 1'b0;
            beat_valid_q <= 1'b1;
            marker_q     <= 1'b0;               // unmarked high half.
         end
         else
         begin
            beat_valid_q <= 1'b0;               // idle pad.
            marker_q     <= 1'b0;
         end
      end
   end

   // payload, qualified by beat_valid_q.
   always_ff @(posedge wr_clk)
   begin
      if (tx_fire)
      begin
         beat_q <= tx_data[BEAT_WIDTH-1:0];     // low half goes first.
         hi_q   <= tx_data[WORD_WIDTH-1:BEAT_WIDTH];
      end
      else if (pending_q)
      begin
         beat_q <= hi_q;                        // then the high half.
      end
   end

   assign credits    = credits_q;
   assign beat       = beat_q;
   assign beat_valid = beat_valid_q;
   assign marker     = marker_q;

endmodule : aib_tx_path

`default_nettype wire

// ==== design/emib_ch_m2s2.sv ====
`timescale 1ns/1ps
`default_nettype none

module emib_ch_m2s2
   import aib_pkg::*;
#(
   parameter int BRIDGE_STAGES = 2              // latency per direction.
)
(
   input  wire logic     wr_clk,
   input  wire logic     rst_n,
   input  wire aib_pad_t m_aib_out,
   output      aib_pad_t m_aib_in,
   input  wire aib_pad_t s_aib_out,
   output      aib_pad_t s_aib_in
);

   aib_pad_t m2s_q [BRIDGE_STAGES];             // master to slave chain.
   aib_pad_t s2m_q [BRIDGE_STAGES];             // slave to master chain.

   always_ff @(posedge wr_clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < BRIDGE_STAGES; i++)
         begin
            m2s_q[i] <= '0;                     // quiet pads out of reset.
            s2m_q[i] <= '0;
         end
      end
      else
      begin
         m2s_q[0] <= m_aib_out;
         s2m_q[0] <= s_aib_out;
         for (int i = 1; i < BRIDGE_STAGES; i++)
         begin
            m2s_q[i] <= m2s_q[i-1];             // shift along the interposer.
            s2m_q[i] <= s2m_q[i-1];
         end
      end
   end

   assign s_aib_in = m2s_q[BRIDGE_STAGES-1];
   assign m_aib_in = s2m_q[BRIDGE_STAGES-1];

endmodule : emib_ch_m2s2

`default_nettype wire

// ==== verif/aib_link_tb_tasks.svh ====
`ifndef AIB_LINK_TB_TASKS_SVH
`define AIB_LINK_TB_TASKS_SVH

// 80-bit word from three seeded draws.
function automatic aib_word_t rand_word();
   logic [95:0] r;
   r = {$random(seed), $random(seed), $random(seed)};
   return r[WORD_WIDTH-1:0];
endfunction

function automatic logic rand_bit();
   logic [31:0] r;
   r = $random(seed);
   return r[0];
endfunction

// one clock of both transmit drivers.
task automatic step_cycle(input int m_total, input int s_total);
   @(posedge wr_clk);
   #1;
   if (m_pend)
   begin
      m_sent++;                                 // taken at the edge just passed.
      ms_tx_valid = 1'b0;
   end
   if (s_pend)
   begin
      s_sent++;
      sl_tx_valid = 1'b0;
   end
   if (!ms_tx_valid && m_sent < m_total)
   begin
      ms_tx_valid = 1'b1;
      ms_tx_data  = rand_word();
   end
   if (!sl_tx_valid && s_sent < s_total)
   begin
      sl_tx_valid = 1'b1;
      sl_tx_data  = rand_word();
   end
   m_pend = ms_tx_valid && ms_tx_ready;         // acceptance due at the next edge.
   s_pend = sl_tx_valid && sl_tx_ready;
endtask

task automatic avmm_write(input bit slave, input csr_addr_e addr, input logic [15:0] data);
   avmm_req_t req;
   req           = '0;
   req.address   = addr;
   req.write     = 1'b1;
   req.writedata = data;
   if (slave)
      sl_avmm_req = req;
   else
      ms_avmm_req = req;
   @(posedge wr_clk);
   #1;
   sl_avmm_req = '0;
   ms_avmm_req = '0;
endtask

task automatic avmm_read(input bit slave, input csr_addr_e addr, output logic [15:0] data);
   avmm_req_t req;
   avmm_rsp_t rsp;
   int        waited;
   req         = '0;
   req.address = addr;
   req.read    = 1'b1;
   if (slave)
      sl_avmm_req = req;
   else
      ms_avmm_req = req;
   @(posedge wr_clk);
   #1;
   sl_avmm_req = '0;
   ms_avmm_req = '0;
   waited = 0;
   rsp = slave ? sl_avmm_rsp : ms_avmm_rsp;
   while (!rsp.readdatavalid && waited < 8)
   begin
      @(posedge wr_clk);
      #1;
      waited++;
      rsp = slave ? sl_avmm_rsp : ms_avmm_rsp;
   end
   data = rsp.readdata;
   if (!rsp.readdatavalid)
   begin
      report_failure($sformatf("no read response for register %s", addr.name()));
      data = 'x;
   end
   else if (waited != 0)
      note_mismatch($sformatf("read of %s answered %0d cycles late", addr.name(), waited));
endtask

task automatic wait_drained(input int limit, input string what);
   int n;
   n = 0;
   while ((m2s_q.size() != 0 || s2m_q.size() != 0) && n < limit)
   begin
      @(posedge wr_clk);
      #1;
      n++;
   end
   if (m2s_q.size() != 0 || s2m_q.size() != 0)
      report_failure($sformatf("%s: sent words never arrived", what));
endtask

task automatic reset_defaults();
   int          errs;
   logic [15:0] rd;
   errs = error_count;
   if (ms_tx_ready || sl_tx_ready)
      note_mismatch("tx_ready high after reset");
   if (ms_rx_valid || sl_rx_valid)
      note_mismatch("rx_valid high after reset");
   if (ms_avmm_rsp.readdatavalid || sl_avmm_rsp.readdatavalid)
      note_mismatch("readdatavalid high after reset");
   for (int s = 0; s < 2; s++)
   begin
      string nm;
      nm = (s != 0) ? "slave" : "master";
      avmm_read(s != 0, REG_CTRL, rd);
      if (rd !== 16'h0000)
         note_mismatch($sformatf("%s REG_CTRL reads %h, expected 0000", nm, rd));
      avmm_read(s != 0, REG_STATUS, rd);
      if (rd[7:4] !== 4'(RX_DEPTH) || rd[0] !== 1'b0)
         note_mismatch($sformatf("%s REG_STATUS reads %h after reset", nm, rd));
      avmm_read(s != 0, REG_TX_WORDS, rd);
      if (rd !== 16'h0000)
         note_mismatch($sformatf("%s REG_TX_WORDS reads %h, expected 0000", nm, rd));
      avmm_read(s != 0, REG_RX_WORDS, rd);
      if (rd !== 16'h0000)
         note_mismatch($sformatf("%s REG_RX_WORDS reads %h, expected 0000", nm, rd));
   end
   end_test("reset defaults", errs);
endtask

task automatic single_word_latency();
   int          errs;
   int          n;
   int          accept_edge;
   aib_word_t   w;
   logic [15:0] rd;
   errs = error_count;
   avmm_write(1'b0, REG_CTRL, 16'h0001);
   w           = rand_word();
   ms_tx_valid = 1'b1;
   ms_tx_data  = w;
   n = 0;
   while (!ms_tx_ready && n < 10)
   begin
      @(posedge wr_clk);
      #1;
      n++;
   end
   if (!ms_tx_ready)
   begin
      report_failure("master tx_ready never rose after tx_en was set");
      ms_tx_valid = 1'b0;
   end
   else
   begin
      accept_edge = cycle_cnt + 1;              // edge that takes the word.
      @(posedge wr_clk);
      #1;
      ms_tx_valid = 1'b0;
      n = 0;
      while (!sl_rx_valid && n < 30)
      begin
         @(posedge wr_clk);
         #1;
         n++;
      end
      if (!sl_rx_valid)
         report_failure("single word never reached the slave receive port");
      else
      begin
         if (cycle_cnt != accept_edge + BRIDGE_STAGES + 3)
            note_mismatch($sformatf("rx_valid rose after edge %0d, expected edge %0d",
                                    cycle_cnt, accept_edge + BRIDGE_STAGES + 3));
         if (sl_rx_data !== w)
            note_mismatch($sformatf("slave rx_data %h, expected %h", sl_rx_data, w));
      end
   end
   wait_drained(50, "single word");
   avmm_read(1'b1, REG_STATUS, rd);
   if (rd[0] !== 1'b1)
      note_mismatch("slave REG_STATUS aligned bit clear after a word");
   end_test("single word latency", errs);
endtask

task automatic bidir_stream();
   int errs;
   int n;
   int m_rx_before;
   int s_rx_before;
   errs        = error_count;
   m_rx_before = m_rx_count;
   s_rx_before = s_rx_count;
   avmm_write(1'b1, REG_CTRL, 16'h0001);        // master already enabled.
   m_sent = 0;
   s_sent = 0;
   m_pend = 1'b0;
   s_pend = 1'b0;
   n = 0;
   while ((m_sent < STREAM_WORDS || s_sent < STREAM_WORDS ||
           m2s_q.size() != 0 || s2m_q.size() != 0) && n < 3000)
   begin
      step_cycle(STREAM_WORDS, STREAM_WORDS);
      ms_rx_ready = rand_bit();                 // random sink stalls.
      sl_rx_ready = rand_bit();
      n++;
   end
   ms_rx_ready = 1'b1;
   sl_rx_ready = 1'b1;
   if (m_sent < STREAM_WORDS || s_sent < STREAM_WORDS ||
       m2s_q.size() != 0 || s2m_q.size() != 0)
      report_failure("bidirectional stream did not complete in time");
   if (s_rx_count - s_rx_before != STREAM_WORDS)
      note_mismatch($sformatf("slave delivered %0d words, expected %0d",
                              s_rx_count - s_rx_before, STREAM_WORDS));
   if (m_rx_count - m_rx_before != STREAM_WORDS)
      note_mismatch($sformatf("master delivered %0d words, expected %0d",
                              m_rx_count - m_rx_before, STREAM_WORDS));
   end_test("bidirectional stream", errs);
endtask

task automatic credit_backpressure();
   int errs;
   int n;
   int high_cycles;
   errs        = error_count;
   sl_rx_ready = 1'b0;                          // slave buffer fills up.
   m_sent      = 0;
   s_sent      = 0;
   m_pend      = 1'b0;
   s_pend      = 1'b0;
   n = 0;
   while (m_sent < RX_DEPTH && n < 100)
   begin
      step_cycle(RX_DEPTH + 3, 0);
      n++;
   end
   if (m_sent < RX_DEPTH)
      report_failure("master stopped before spending all of its credits");
   high_cycles = 0;
   for (int i = 0; i < 30; i++)
   begin
      step_cycle(RX_DEPTH + 3, 0);
      if (ms_tx_ready)
         high_cycles++;
   end
   if (high_cycles != 0)
      note_mismatch($sformatf("master tx_ready high %0d cycles with no credits", high_cycles));
   if (m_sent != RX_DEPTH)
      note_mismatch($sformatf("master accepted %0d words, expected %0d", m_sent, RX_DEPTH));
   sl_rx_ready = 1'b1;
   n = 0;
   while ((m_sent < RX_DEPTH + 3 || m2s_q.size() != 0) && n < 300)
   begin
      step_cycle(RX_DEPTH + 3, 0);
      n++;
   end
   if (m_sent < RX_DEPTH + 3 || m2s_q.size() != 0)
      report_failure("words held back by missing credits never went through");
   end_test("credit back-pressure", errs);
endtask

task automatic counter_readback();
   int          errs;
   int          n;
   logic [15:0] rd;
   errs = error_count;
   avmm_read(1'b0, REG_TX_WORDS, rd);
   if (rd !== 16'(m_tx_count))
      note_mismatch($sformatf("master REG_TX_WORDS %0d, expected %0d", rd, m_tx_count));
   avmm_read(1'b1, REG_RX_WORDS, rd);
   if (rd !== 16'(s_rx_count))
      note_mismatch($sformatf("slave REG_RX_WORDS %0d, expected %0d", rd, s_rx_count));
   avmm_read(1'b1, REG_TX_WORDS, rd);
   if (rd !== 16'(s_tx_count))
      note_mismatch($sformatf("slave REG_TX_WORDS %0d, expected %0d", rd, s_tx_count));
   avmm_read(1'b0, REG_RX_WORDS, rd);
   if (rd !== 16'(m_rx_count))
      note_mismatch($sformatf("master REG_RX_WORDS %0d, expected %0d", rd, m_rx_count));
   for (int s = 0; s < 2; s++)
   begin
      n = 0;
      avmm_read(s != 0, REG_STATUS, rd);
      while (rd[7:4] !== 4'(RX_DEPTH) && n < 20)
      begin
         avmm_read(s != 0, REG_STATUS, rd);      // credits may still be in flight.
         n++;
      end
      if (rd[7:4] !== 4'(RX_DEPTH))
         note_mismatch($sformatf("side %0d credits %0d, expected %0d", s, rd[7:4], RX_DEPTH));
   end
   end_test("counters and credit return", errs);
endtask

task automatic tx_disable();
   int errs;
   int n;
   int bad;
   int rx_before;
   errs = error_count;
   avmm_write(1'b0, REG_CTRL, 16'h0000);
   if (ms_tx_ready)
      note_mismatch("master tx_ready still high after tx_en was cleared");
   rx_before = s_rx_count;
   m_sent    = 0;
   s_sent    = 0;
   m_pend    = 1'b0;
   s_pend    = 1'b0;
   bad       = 0;
   for (int i = 0; i < 20; i++)
   begin
      step_cycle(1, 0);                         // offered word must stall.
      if (ms_tx_ready || sl_rx_valid)
         bad++;
   end
   if (bad != 0 || m_sent != 0 || s_rx_count != rx_before)
      note_mismatch($sformatf("traffic seen with tx_en clear, %0d bad cycles", bad));
   avmm_write(1'b0, REG_CTRL, 16'h0001);
   m_pend = ms_tx_valid && ms_tx_ready;         // ready again after the write.
   n = 0;
   while ((m_sent < 1 || m2s_q.size() != 0) && n < 100)
   begin
      step_cycle(1, 0);
      n++;
   end
   if (m_sent < 1 || m2s_q.size() != 0)
      report_failure("transfers did not resume after tx_en was set again");
   else if (s_rx_count != rx_before + 1)
      note_mismatch($sformatf("slave delivered %0d words after resume, expected 1",
                              s_rx_count - rx_before));
   end_test("transmit disable", errs);
endtask

`endif

// ==== verif/aib_link_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aib_link_tb
   import aib_pkg::*;
();

   localparam int RX_DEPTH      = 4;            // far buffer depth and credits.
   localparam int BRIDGE_STAGES = 2;            // interposer latency per direction.
   localparam int STREAM_WORDS  = 20;           // words per direction, stream test.

   logic      wr_clk;
   logic      rst_n;
   avmm_req_t ms_avmm_req;
   avmm_req_t sl_avmm_req;
   avmm_rsp_t ms_avmm_rsp;
   avmm_rsp_t sl_avmm_rsp;
   logic      ms_tx_valid, ms_tx_ready, ms_rx_valid, ms_rx_ready;
   logic      sl_tx_valid, sl_tx_ready, sl_rx_valid, sl_rx_ready;
   aib_word_t ms_tx_data, ms_rx_data;
   aib_word_t sl_tx_data, sl_rx_data;

   integer    seed;                             // random stream state.
   int        cycle_cnt   = 0;                  // rising edges so far.
   int        error_count = 0;
   int        pass_tests  = 0;
   int        fail_tests  = 0;

   aib_word_t m2s_q[$];                         // expected at the slave.
   aib_word_t s2m_q[$];                         // expected at the master.
   int        m_tx_count = 0;                   // words accepted, master.
   int        s_tx_count = 0;
   int        m_rx_count = 0;                   // words popped, master.
   int        s_rx_count = 0;

   int        m_sent, s_sent;                   // driver progress per test.
   logic      m_pend, s_pend;                   // acceptance due at next edge.

   aib_link_top #(
      .RX_DEPTH      (RX_DEPTH),
      .BRIDGE_STAGES (BRIDGE_STAGES)
   ) UUT (
      .wr_clk      (wr_clk),
      .rst_n       (rst_n),
      .ms_avmm_req (ms_avmm_req),
      .ms_avmm_rsp (ms_avmm_rsp),
      .sl_avmm_req (sl_avmm_req),
      .sl_avmm_rsp (sl_avmm_rsp),
      .ms_tx_valid (ms_tx_valid),
      .ms_tx_data  (ms_tx_data),
      .ms_tx_ready (ms_tx_ready),
      .ms_rx_valid (ms_rx_valid),
      .ms_rx_data  (ms_rx_data),
      .ms_rx_ready (ms_rx_ready),
      .sl_tx_valid (sl_tx_valid),
      .sl_tx_data  (sl_tx_data),
      .sl_tx_ready (sl_tx_ready),
      .sl_rx_valid (sl_rx_valid),
      .sl_rx_data  (sl_rx_data),
      .sl_rx_ready (sl_rx_ready)
   );

   // 20 ns clock.
   initial
   begin
      wr_clk = 1'b0;
      forever #10 wr_clk = ~wr_clk;
   end

   always @(posedge wr_clk)
      cycle_cnt <= cycle_cnt + 1;

   task automatic note_mismatch(input string msg);
      $display("Mismatch at %0t: %s", $time, msg);
      error_count++;
   endtask

   task automatic report_failure(input string msg);
      $display("Error at %0t: %s", $time, msg);
      error_count++;
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (error_count == errs_before)
      begin
         pass_tests++;
         $display("[%0t] test %s ok", $time, name);
      end
      else
      begin
         fail_tests++;
         $display("[%0t] test %s failed, %0d errors", $time, name, error_count - errs_before);
      end
   endtask

   // scoreboard, sampled mid-cycle where every signal is settled.
   always @(negedge wr_clk)
   begin : scoreboard
      aib_word_t exp;
      if (rst_n)
      begin
         if (ms_tx_valid && ms_tx_ready)
         begin
            m2s_q.push_back(ms_tx_data);        // taken at the next edge.
            m_tx_count++;
         end
         if (sl_tx_valid && sl_tx_ready)
         begin
            s2m_q.push_back(sl_tx_data);
            s_tx_count++;
         end
         if (sl_rx_valid && sl_rx_ready)
         begin
            s_rx_count++;
            if (m2s_q.size() == 0)
               report_failure("slave delivered a word the master never sent");
            else
            begin
               exp = m2s_q.pop_front();
               if (sl_rx_data !== exp)
                  note_mismatch($sformatf("slave rx_data %h, expected %h", sl_rx_data, exp));
            end
         end
         if (ms_rx_valid && ms_rx_ready)
         begin
            m_rx_count++;
            if (s2m_q.size() == 0)
               report_failure("master delivered a word the slave never sent");
            else
            begin
               exp = s2m_q.pop_front();
               if (ms_rx_data !== exp)
                  note_mismatch($sformatf("master rx_data %h, expected %h", ms_rx_data, exp));
            end
         end
      end
   end

   `include "aib_link_tb_tasks.svh"

   initial
   begin : main
      seed        = 32'hc96d;
      rst_n       = 1'b0;
      ms_avmm_req = '0;
      sl_avmm_req = '0;
      ms_tx_valid = 1'b0;
      sl_tx_valid = 1'b0;
      ms_tx_data  = '0;
      sl_tx_data  = '0;
      ms_rx_ready = 1'b1;                       // sinks open by default.
      sl_rx_ready = 1'b1;
      m_sent      = 0;
      s_sent      = 0;
      m_pend      = 1'b0;
      s_pend      = 1'b0;
      repeat (8) @(posedge wr_clk);
      #1;
      rst_n = 1'b1;

      reset_defaults();
      single_word_latency();
      bidir_stream();
      credit_backpressure();
      counter_readback();
      tx_disable();

      $display("tests passed %0d, tests failed %0d, errors %0d",
               pass_tests, fail_tests, error_count);
      if (fail_tests == 0 && error_count == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   // hard stop for a hung run.
   initial
   begin
      #1_000_000;
      $display("Error: simulation time limit reached before the tests finished");
      $display("Result: FAILED");
      $finish;
   end

endmodule : aib_link_tb

`default_nettype wire
